// ==== dv/ws2812_vectors.mem ====
// One 24-bit GRB pixel per line in hex, G in the top byte
// Sent in order, each line is also the expected decoded value
FF0000
00FF00
0000FF
FFFFFF
000000
A5A5A5
5A5A5A
123456
80017F
0F0F0F
F0F0F0
C3C33C
7E8100
00AA55
DEAD01
13579B

// ==== build.f ====
logic/pio_pkg.sv
logic/pio_tx_fifo.sv
logic/pio_sm.sv
logic/pio.sv
logic/pio_loader.sv
logic/ws2812_top.sv
dv/tb_ws2812.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the WS2812 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ws2812 -f build.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// ==== dv/tb_ws2812.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ws2812;

  logic                clk_25mhz;
  logic                pwr_up_reset_n;
  pio_pkg::pixel_t     pixel_in;
  logic                pixel_load;
  logic                fifo_full;
  logic                ready;
  logic                dout;
  pio_pkg::stall_cnt_t stall_count;

  pio_pkg::pixel_t     vec [16];
  pio_pkg::pixel_t     exp_q [$];      // Pixels accepted into the FIFO
  pio_pkg::pixel_t     rx_q [$];       // Pixels decoded from dout
  pio_pkg::pixel_t     shift_reg = '0;
  pio_pkg::pixel_t     fill_px;
  pio_pkg::stall_cnt_t stall_before;
  logic [31:0]         rnd;
  integer              seed;
  integer              errors;
  integer              timeouts;
  integer              hi_len = 0;
  integer              bit_cnt = 0;
  integer              pulses = 0;
  integer              pulse_errors = 0;
  integer              pulses_before;
  integer              cycles;
  integer              tries;
  integer              i;
  logic                timed_out;
  logic                full_ok;

  ws2812_top UUT (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .pixel_in       (pixel_in),
    .pixel_load     (pixel_load),
    .fifo_full      (fifo_full),
    .ready          (ready),
    .dout           (dout),
    .stall_count    (stall_count)
  );

  always #20 clk_25mhz = ~clk_25mhz;

  // Pulse decoder samples dout before each rising edge updates it
  always @(posedge clk_25mhz) begin
    if (dout) begin
      hi_len = hi_len + 1;
    end else if (hi_len != 0) begin
      pulses = pulses + 1;
      if (hi_len != 6 && hi_len != 21) begin
        pulse_errors = pulse_errors + 1;
        $display("Pulse on dout lasted %0d clocks instead of 6 or 21", hi_len);
      end
      shift_reg = {shift_reg[22:0], (hi_len > 12)};  // Long pulse is a 1
      bit_cnt   = bit_cnt + 1;
      if (bit_cnt == 24) begin
        rx_q.push_back(shift_reg);
        bit_cnt = 0;
      end
      hi_len = 0;
    end
  end

  task automatic report_value(input string name, input logic [31:0] expv,
                              input logic [31:0] got);
    errors = errors + 1;
    $display("ERR %s expected %h got %h", name, expv, got);
  endtask

  task automatic report_timeout(input string what);
    timeouts  = timeouts + 1;
    timed_out = 1'b1;
    $display("Timeout while waiting for %s", what);
  endtask

  // One-cycle strobe that returns once the push reaches the FIFO
  task automatic strobe(input pio_pkg::pixel_t p);
    @(posedge clk_25mhz);
    pixel_in   <= p;
    pixel_load <= 1'b1;
    @(posedge clk_25mhz);
    pixel_load <= 1'b0;
    @(posedge clk_25mhz);
  endtask

  task automatic send_pixel(input pio_pkg::pixel_t p);
    integer n;
    n = 0;
    @(negedge clk_25mhz);
    while (!timed_out && fifo_full && n < 3000) begin
      @(negedge clk_25mhz);
      n = n + 1;
    end
    if (!timed_out && fifo_full)
      report_timeout("fifo_full to drop");
    if (!fifo_full) begin
      strobe(p);
      exp_q.push_back(p);
    end
  endtask

  task automatic wait_rx(input integer n);
    integer k;
    k = 0;
    while (!timed_out && rx_q.size() < n && k < 20000) begin
      @(negedge clk_25mhz);
      k = k + 1;
    end
    if (!timed_out && rx_q.size() < n)
      report_timeout("decoded pixels");
  endtask

  // Counts rising edges from reset release until ready is seen
  task automatic wait_ready;
    cycles = 0;
    while (!timed_out && !ready && cycles < 100) begin
      @(posedge clk_25mhz);
      cycles = cycles + 1;
      @(negedge clk_25mhz);
    end
    if (!timed_out && !ready)
      report_timeout("ready");
  endtask

  task automatic wait_dout_rise;
    integer k;
    logic   prev;
    k    = 0;
    prev = 1'b1;  // A line that is already high does not count
    while (!timed_out && !(dout && !prev) && k < 200) begin
      prev = dout;
      @(negedge clk_25mhz);
      k = k + 1;
    end
    if (!timed_out && !(dout && !prev))
      report_timeout("a rising edge on dout");
  endtask

  initial begin
    clk_25mhz      = 1'b0;
    pwr_up_reset_n = 1'b0;
    pixel_in       = '0;
    pixel_load     = 1'b0;
    errors         = 0;
    timeouts       = 0;
    timed_out      = 1'b0;
    seed           = 8521;
    $readmemh("dv/ws2812_vectors.mem", vec);

    repeat (8) @(posedge clk_25mhz);
    pwr_up_reset_n <= 1'b1;
    @(negedge clk_25mhz);
    if (ready !== 1'b0) report_value("ready", 0, ready);
    if (dout !== 1'b0) report_value("dout", 0, dout);
    if (stall_count !== 8'd0) report_value("stall_count", 0, stall_count);
    wait_ready();
    if (cycles != 38) report_value("ready latency", 38, cycles);

    // First pixel on its own
    send_pixel(vec[0]);
    wait_rx(1);
    if (rx_q.size() > 0 && rx_q[0] !== vec[0]) report_value("pixel 0", vec[0], rx_q[0]);

    for (i = 1; i < 16; i = i + 1)
      send_pixel(vec[i]);
    wait_rx(16);
    if (rx_q.size() != 16) begin
      report_value("decoded count", 16, rx_q.size());
    end else begin
      for (i = 0; i < 16; i = i + 1)
        if (rx_q[i] !== vec[i]) report_value($sformatf("pixel %0d", i), vec[i], rx_q[i]);
    end

    // Fill the FIFO and retry when a pop frees a slot before the extra strobe
    full_ok = 1'b0;
    tries   = 0;
    while (!timed_out && !full_ok && tries < 4) begin
      tries = tries + 1;
      i     = 0;
      @(negedge clk_25mhz);
      while (!fifo_full && i < 8) begin
        rnd     = $random(seed);
        fill_px = rnd[23:0];
        if (fill_px == 24'hABCDEF)
          fill_px = 24'h0;
        send_pixel(fill_px);
        @(negedge clk_25mhz);
        i = i + 1;
      end
      wait_dout_rise();  // Next pop is at least 21 clocks away
      full_ok = fifo_full;
    end
    if (!full_ok) begin
      errors = errors + 1;
      $display("fifo_full could not be held high for the overflow strobe");
    end
    stall_before = stall_count;
    strobe(24'hABCDEF);
    @(negedge clk_25mhz);
    if (stall_count !== stall_before + 8'd1)
      report_value("stall_count", stall_before + 8'd1, stall_count);

    wait_rx(exp_q.size());
    repeat (1500) @(posedge clk_25mhz);  // Room for a stray pixel
    if (rx_q.size() != exp_q.size()) begin
      report_value("decoded count", exp_q.size(), rx_q.size());
    end else begin
      for (i = 16; i < rx_q.size(); i = i + 1)
        if (rx_q[i] !== exp_q[i]) report_value($sformatf("pixel %0d", i), exp_q[i], rx_q[i]);
    end
    foreach (rx_q[j]) begin
      if (rx_q[j] == 24'hABCDEF) begin
        errors = errors + 1;
        $display("The dropped pixel ABCDEF was sent on dout");
      end
    end

    // Idle line after drain
    repeat (2000) begin
      @(negedge clk_25mhz);
      if (dout !== 1'b0) report_value("dout", 0, dout);
    end

    // Strobe while the loader is still busy after a second reset
    @(posedge clk_25mhz);
    pwr_up_reset_n <= 1'b0;
    repeat (8) @(posedge clk_25mhz);
    pwr_up_reset_n <= 1'b1;
    pulses_before = pulses;
    strobe(24'h5A5A5A);
    @(negedge clk_25mhz);
    if (ready !== 1'b0) report_value("ready", 0, ready);
    wait_ready();
    repeat (1000) @(posedge clk_25mhz);
    @(negedge clk_25mhz);
    if (stall_count !== 8'd0) report_value("stall_count", 0, stall_count);
    if (pulses != pulses_before) report_value("pulse count", pulses_before, pulses);
    if (bit_cnt != 0) begin
      errors = errors + 1;
      $display("A partial pixel of %0d bits was left on dout", bit_cnt);
    end

    $display("Errors: %0d checks, %0d pulse widths, %0d timeouts",
             errors, pulse_errors, timeouts);
    if (errors == 0 && pulse_errors == 0 && timeouts == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/ws2812_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ws2812_top (
  input  wire logic            clk_25mhz,
  input  wire logic            pwr_up_reset_n,
  input  wire pio_pkg::pixel_t pixel_in,
  input  wire logic            pixel_load,
  output wire logic            fifo_full,
  output wire logic            ready,
  output wire logic            dout,
  output pio_pkg::stall_cnt_t  stall_count
);

  pio_pkg::word_t   din;
  pio_pkg::pc_t     index;
  pio_pkg::action_t action;

  pio_loader loader (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .pixel_in       (pixel_in),
    .pixel_load     (pixel_load),
    .full           (fifo_full),
    .din            (din),
    .index          (index),
    .action         (action),
    .ready          (ready),
    .stall_count    (stall_count)
  );

  pio pio_1 (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .din            (din),
    .index          (index),
    .action         (action),
    .full           (fifo_full),
    .empty          (),
    .dout           (dout)  // Side-set pin drives the chain
  );

endmodule

`default_nettype wire

// ==== logic/pio_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_loader (
  input  wire logic            clk_25mhz,
  input  wire logic            pwr_up_reset_n,
  input  wire pio_pkg::pixel_t pixel_in,
  input  wire logic            pixel_load,
  input  wire logic            full,
  output pio_pkg::word_t       din,
  output pio_pkg::pc_t         index,
  output pio_pkg::action_t     action,
  output logic                 ready,
  output pio_pkg::stall_cnt_t  stall_count
);

  typedef enum logic [1:0] {
    LOAD,    // Copy program into imem
    CONFIG,  // Walk the config list
    RUN      // Forward pixels
  } ld_state_t;

  ld_state_t                               state;
  pio_pkg::pc_t                            pindex;
  logic [$clog2(pio_pkg::conf_len+1)-1:0] cindex;

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      state       <= LOAD;
      pindex      <= '0;
      cindex      <= '0;
      din         <= '0;
      index       <= '0;
      action      <= pio_pkg::ACT_NONE;
      ready       <= 1'b0;
      stall_count <= '0;
    end else begin
      case (state)
        LOAD: begin
          action <= pio_pkg::ACT_INSTR;
          din    <= {16'd0, pio_pkg::ws_program[pindex]};
          index  <= pindex;
          pindex <= pindex + 5'd1;
          if (pindex == 5'd31)
            state <= CONFIG;
        end

        CONFIG: begin
          if (cindex == pio_pkg::conf_len) begin
            action <= pio_pkg::ACT_NONE;
            ready  <= 1'b1;
            state  <= RUN;
          end else begin
            action <= pio_pkg::ws_conf[cindex].action;
            din    <= pio_pkg::ws_conf[cindex].data;
            cindex <= cindex + 1'b1;
          end
        end

        RUN: begin
          action <= pio_pkg::ACT_NONE;
          if (pixel_load) begin
            if (!full) begin
              action <= pio_pkg::ACT_PUSH;
              din    <= {pixel_in, 8'd0};  // MSB aligned for left shift
            end else if (stall_count != 8'hff) begin
              stall_count <= stall_count + 8'd1;  // Dropped pixel
            end
          end
        end

        default: state <= LOAD;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/pio.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio (
  input  wire logic             clk_25mhz,
  input  wire logic             pwr_up_reset_n,
  input  wire pio_pkg::word_t   din,
  input  wire pio_pkg::pc_t     index,
  input  wire pio_pkg::action_t action,
  output wire logic             full,
  output wire logic             empty,
  output wire logic             dout
);

  pio_pkg::instr_t  imem [32];  // Program memory
  pio_pkg::sm_cfg_t cfg;
  pio_pkg::pc_t     sm_pc;
  pio_pkg::pc_t     jump_pc;
  pio_pkg::instr_t  sm_instr;
  pio_pkg::word_t   fifo_rdata;
  logic             push;
  logic             pop;
  logic             jump;

  assign push     = (action == pio_pkg::ACT_PUSH);
  assign jump     = (action == pio_pkg::ACT_JUMP);
  assign jump_pc  = din[4:0];
  assign sm_instr = imem[sm_pc];

  always_ff @(posedge clk_25mhz) begin
    if (action == pio_pkg::ACT_INSTR)
      imem[index] <= din[15:0];
  end

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      cfg             <= '0;
      cfg.clkdiv      <= 16'd1;
      cfg.wrap_top    <= 5'd31;  // Full program until configured
      cfg.pull_thresh <= 6'd32;
    end else begin
      case (action)
        pio_pkg::ACT_CLKDIV: cfg.clkdiv <= din[15:0];
        pio_pkg::ACT_EXECCTRL: begin
          cfg.wrap_top    <= din[4:0];
          cfg.wrap_bottom <= din[9:5];
          cfg.sideset_en  <= din[10];
        end
        pio_pkg::ACT_SHIFTCTRL: begin
          cfg.autopull    <= din[0];
          cfg.pull_thresh <= (din[5:1] == 5'd0) ? 6'd32 : {1'b0, din[5:1]};
        end
        pio_pkg::ACT_ENABLE: cfg.enable <= din[0];
        default: ;
      endcase
    end
  end

  pio_tx_fifo tx_fifo (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .push           (push),
    .wdata          (din),
    .pop            (pop),
    .rdata          (fifo_rdata),
    .full           (full),
    .empty          (empty)
  );

  pio_sm sm (
    .clk_25mhz      (clk_25mhz),
    .pwr_up_reset_n (pwr_up_reset_n),
    .cfg            (cfg),
    .instr          (sm_instr),
    .pc             (sm_pc),
    .jump           (jump),
    .jump_pc        (jump_pc),
    .fifo_data      (fifo_rdata),
    .fifo_empty     (empty),
    .pop            (pop),
    .side_out       (dout)
  );

endmodule

`default_nettype wire

// ==== logic/pio_sm.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_sm (
  input  wire logic             clk_25mhz,
  input  wire logic             pwr_up_reset_n,
  input  wire pio_pkg::sm_cfg_t cfg,
  input  wire pio_pkg::instr_t  instr,
  output pio_pkg::pc_t          pc,
  input  wire logic             jump,
  input  wire pio_pkg::pc_t     jump_pc,
  input  wire pio_pkg::word_t   fifo_data,
  input  wire logic             fifo_empty,
  output logic                  pop,
  output logic                  side_out
);

  pio_pkg::opcode_t op;
  pio_pkg::word_t   osr;
  pio_pkg::word_t   x;
  pio_pkg::word_t   out_src;  // OSR or fresh FIFO word on autopull
  pio_pkg::pc_t     next_pc;
  logic [15:0]      div_cnt;
  logic [5:0]       osr_cnt;  // Bits shifted out, 32 is empty
  logic [5:0]       out_n;
  logic [6:0]       cnt_sum;
  logic [4:0]       delay_cnt;
  logic [4:0]       delay_field;
  logic             side_val;
  logic             tick;
  logic             exec;
  logic             need_refill;
  logic             stall;
  logic             take_jmp;

  always_comb begin
    op          = pio_pkg::opcode_t'(instr[15:13]);
    side_val    = instr[12];
    delay_field = cfg.sideset_en ? {1'b0, instr[11:8]} : instr[12:8];
    out_n       = (instr[4:0] == 5'd0) ? 6'd32 : {1'b0, instr[4:0]};

    tick = cfg.enable && ((cfg.clkdiv <= 16'd1) || (div_cnt >= cfg.clkdiv - 16'd1));
    exec = tick && (delay_cnt == 5'd0);

    need_refill = cfg.autopull && (osr_cnt >= cfg.pull_thresh);
    out_src     = need_refill ? fifo_data : osr;
    cnt_sum     = (need_refill ? 7'd0 : {1'b0, osr_cnt}) + {1'b0, out_n};
    next_pc     = (pc == cfg.wrap_top) ? cfg.wrap_bottom : pc + 5'd1;

    stall    = 1'b0;
    pop      = 1'b0;
    take_jmp = 1'b0;
    case (op)
      pio_pkg::OP_OUT: begin
        if (need_refill) begin
          if (fifo_empty)
            stall = 1'b1;  // Wait for data, delay not started
          else
            pop = exec;
        end
      end
      pio_pkg::OP_PULL: begin
        if (fifo_empty)
          stall = instr[5];  // Blocking pull only
        else
          pop = exec;
      end
      pio_pkg::OP_JMP: begin
        case (instr[7:5])
          3'd0:    take_jmp = 1'b1;
          3'd1:    take_jmp = (x == '0);  // !x
          3'd2:    take_jmp = (x != '0);  // x--
          default: take_jmp = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      div_cnt   <= '0;
      pc        <= '0;
      osr       <= '0;
      osr_cnt   <= 6'd32;
      x         <= '0;
      delay_cnt <= '0;
      side_out  <= 1'b0;
    end else if (jump) begin
      // Forced jump restarts the divider and drops any delay
      pc        <= jump_pc;
      delay_cnt <= '0;
      div_cnt   <= '0;
    end else begin
      if (tick || !cfg.enable)
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 16'd1;

      if (tick) begin
        if (delay_cnt != 5'd0) begin
          delay_cnt <= delay_cnt - 5'd1;
        end else begin
          if (cfg.sideset_en)
            side_out <= side_val;  // Also holds during a stall
          if (!stall) begin
            delay_cnt <= delay_field;
            pc        <= next_pc;
            case (op)
              pio_pkg::OP_JMP: begin
                if (take_jmp)
                  pc <= instr[4:0];
                if (instr[7:5] == 3'd2)
                  x <= x - 32'd1;
              end
              pio_pkg::OP_OUT: begin
                if (instr[7:5] == 3'd1)
                  x <= out_src >> (6'd32 - out_n);  // Top n bits, MSB first
                osr     <= out_src << out_n;
                osr_cnt <= (cnt_sum > 7'd32) ? 6'd32 : cnt_sum[5:0];
              end
              pio_pkg::OP_PULL: begin
                osr     <= fifo_empty ? x : fifo_data;  // Nonblocking pull takes X
                osr_cnt <= '0;
              end
              pio_pkg::OP_SET: begin
                if (instr[7:5] == 3'd1)
                  x <= {27'd0, instr[4:0]};
              end
              pio_pkg::OP_MOV: ;  // Only as NOP
              default: ;
            endcase
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/pio_tx_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pio_tx_fifo (
  input  wire logic           clk_25mhz,
  input  wire logic           pwr_up_reset_n,
  input  wire logic           push,
  input  wire pio_pkg::word_t wdata,
  input  wire logic           pop,
  output pio_pkg::word_t      rdata,
  output logic                full,
  output logic                empty
);

  pio_pkg::word_t mem [pio_pkg::fifo_depth];

  logic [$clog2(pio_pkg::fifo_depth)-1:0]   wr_ptr;
  logic [$clog2(pio_pkg::fifo_depth)-1:0]   rd_ptr;
  logic [$clog2(pio_pkg::fifo_depth+1)-1:0] count;
  logic                                     do_push;
  logic                                     do_pop;

  assign full    = (count == pio_pkg::fifo_depth);
  assign empty   = (count == 0);
  assign do_push = push && !full;  // Push into a full FIFO is lost
  assign do_pop  = pop && !empty;
  assign rdata   = mem[rd_ptr];    // Head shown ahead of the pop

  always_ff @(posedge clk_25mhz) begin
    if (do_push)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk_25mhz) begin
    if (!pwr_up_reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == pio_pkg::fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == pio_pkg::fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/pio_pkg.sv ====
`default_nettype none

package pio_pkg;

  typedef logic [31:0] word_t;      // din, dout and FIFO entries
  typedef logic [15:0] instr_t;
  typedef logic [4:0]  pc_t;
  typedef logic [23:0] pixel_t;     // GRB order
  typedef logic [7:0]  stall_cnt_t;

  // Loader to engine commands
  typedef enum logic [3:0] {
    ACT_NONE      = 4'd0,
    ACT_INSTR     = 4'd1,  // imem[index] <= din
    ACT_CLKDIV    = 4'd2,
    ACT_EXECCTRL  = 4'd3,
    ACT_PUSH      = 4'd4,
    ACT_SHIFTCTRL = 4'd5,
    ACT_ENABLE    = 4'd6,
    ACT_JUMP      = 4'd7
  } action_t;

  // Instruction bits [15:13]
  typedef enum logic [2:0] {
    OP_JMP  = 3'd0,
    OP_OUT  = 3'd3,
    OP_PULL = 3'd4,
    OP_MOV  = 3'd5,
    OP_SET  = 3'd7
  } opcode_t;

  typedef struct packed {
    logic [15:0] clkdiv;      // Integer divider, 0 and 1 run every clock
    pc_t         wrap_top;
    pc_t         wrap_bottom;
    logic        sideset_en;  // Bit 12 is the side-set pin
    logic        autopull;
    logic [5:0]  pull_thresh; // 1 to 32
    logic        enable;
  } sm_cfg_t;

  typedef struct packed {
    action_t action;
    word_t   data;
  } conf_entry_t;

  localparam int fifo_depth = 4;
  localparam int conf_len   = 5;

  // WS2812 bit loop, T1=2 T2=5 T3=3 ticks
  localparam instr_t ws_program [32] = '{
    0:       16'h6221,  // out x, 1       side 0 [2]
    1:       16'h1123,  // jmp !x, 3      side 1 [1]
    2:       16'h1400,  // jmp 0          side 1 [4]
    3:       16'hA442,  // nop            side 0 [4]
    default: 16'hA042   // Plain nop
  };

  localparam conf_entry_t ws_conf [conf_len] = '{
    '{action: ACT_CLKDIV,    data: 32'd3},
    '{action: ACT_EXECCTRL,  data: 32'h0000_0403},  // Wrap 3 to 0, side-set on
    '{action: ACT_SHIFTCTRL, data: 32'h0000_0031},  // Autopull at 24 bits
    '{action: ACT_JUMP,      data: 32'd0},
    '{action: ACT_ENABLE,    data: 32'd1}
  };

endpackage

`default_nettype wire
